/* Makefile */
VERILATOR := verilator
TOP       := reg_board_tb
RTL_TOP   := reg_board
FILELIST  := verilog.f
FLAGS     := --timing --assert -Wno-fatal
BUILD     := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "sim passed" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* logic/front_panel_scanner.sv */
// Front panel byte scanner
`timescale 1ns/1ns

module front_panel_scanner (
   input  logic                                    clk4,
   input  logic                                    rst_n,
   input  reg_board_pkg::word_t                    pc_value,
   input  reg_board_pkg::word_t                    dr_value,
   input  reg_board_pkg::word_t                    ac_value,
   input  reg_board_pkg::word_t                    sp_value,
   output reg_board_pkg::fp_byte_t                 fpd,     // Byte on display
   output logic [reg_board_pkg::fp_slot_count-1:0] fp_sel   // One-hot slot strobe
);
   import reg_board_pkg::*;

   fp_slot_e              slot_q;                  // Slot on display
   logic [fp_dwell_w-1:0] dwell_q;                 // Clocks spent on this slot
   logic                  run_q;                   // Out of reset at least once

   ////////////////////////////////////////////////////////////////////////////
   // Slot sequencer
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         slot_q  <= pc_lo;
         dwell_q <= '0;
         run_q   <= 1'b0;
      end else begin
         run_q <= 1'b1;                            // First clock shows pc_lo
         if (run_q) begin
            if (dwell_q == fp_dwell_w'(fp_dwell_cycles - 1)) begin
               dwell_q <= '0;
               slot_q  <= fp_slot_e'(slot_q + 3'd1); // sp_hi wraps to pc_lo
            end else begin
               dwell_q <= dwell_q + 1'b1;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Display outputs
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      fp_sel = '0;                                 // Dark until running
      if (run_q) fp_sel[slot_q] = 1'b1;
      case (slot_q)
         pc_lo:   fpd = pc_value[7:0];
         pc_hi:   fpd = pc_value[15:8];
         dr_lo:   fpd = dr_value[7:0];
         dr_hi:   fpd = dr_value[15:8];
         ac_lo:   fpd = ac_value[7:0];
         ac_hi:   fpd = ac_value[15:8];
         sp_lo:   fpd = sp_value[7:0];
         default: fpd = sp_value[15:8];            // sp_hi
      endcase
   end

endmodule

/* logic/ibus_read_port.sv */
// Processor bus read port
`timescale 1ns/1ns

module ibus_read_port (
   input  logic                                 clk4,
   input  logic                                 rst_n,
   input  logic [reg_board_pkg::reg_count-1:0]  rd_sel,    // One-hot from decoder
   input  reg_board_pkg::word_t                 pc_value,
   input  reg_board_pkg::word_t                 dr_value,
   input  reg_board_pkg::word_t                 ac_value,
   input  reg_board_pkg::word_t                 sp_value,
   output reg_board_pkg::word_t                 ibus_out,  // Data for the bus
   output logic                                 ibus_oe    // Drive the bus
);
   import reg_board_pkg::*;

   logic [reg_count-1:0] sel_q;                    // Select held for one cycle
   logic                 oe_q;

   // The select is registered at the same edge the registers update, so
   // the mux below sees the post-edge value, with any same-cycle write
   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         sel_q <= '0;
         oe_q  <= 1'b0;
      end else begin
         sel_q <= rd_sel;
         oe_q  <= |rd_sel;                         // Any register requested
      end
   end

   always_comb begin
      ibus_out = '0;                               // Idle bus reads as zero
      if (sel_q[reg_pc]) ibus_out = pc_value;
      if (sel_q[reg_dr]) ibus_out = dr_value;
      if (sel_q[reg_ac]) ibus_out = ac_value;
      if (sel_q[reg_sp]) ibus_out = sp_value;
   end

   assign ibus_oe = oe_q;

endmodule

/* logic/major_register.sv */
// Major register with load and step
`timescale 1ns/1ns

module major_register (
   input  logic                 clk4,        // Write phase clock
   input  logic                 rst_n,
   input  reg_board_pkg::word_t load_value,  // Word from the processor bus
   input  logic                 wr,          // Load load_value
   input  logic                 inc,         // Add one
   input  logic                 dec,         // Subtract one
   output reg_board_pkg::word_t value,       // Current contents
   output logic                 zero         // Contents are zero
);

   ////////////////////////////////////////////////////////////////////////////
   // Register update
   ////////////////////////////////////////////////////////////////////////////

   // A bus write wins over a step issued in the same cycle.
   // Steps wrap modulo 2^16 through the natural width of value.
   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         value <= '0;                              // Registers clear on reset
      end else if (wr) begin
         value <= load_value;                      // Load from bus
      end else if (inc) begin
         value <= value + 1'b1;                    // Wraps FFFF to 0000
      end else if (dec) begin
         value <= value - 1'b1;                    // Wraps 0000 to FFFF
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Flags
   ////////////////////////////////////////////////////////////////////////////

   assign zero = (value == '0);                    // Only AC's is used

endmodule

/* logic/microcode_decoder.sv */
// Microcode field decoder
`timescale 1ns/1ns

module microcode_decoder (
   input  microcode_pkg::uaddr_t           raddr,     // Read address field
   input  microcode_pkg::uaddr_t           waddr,     // Write address field
   input  microcode_pkg::uaction_t         action,    // Action field
   output logic [reg_board_pkg::reg_count-1:0] rd_sel, // One-hot read select
   output logic [reg_board_pkg::reg_count-1:0] wr_en,  // Per-register write
   output logic [reg_board_pkg::reg_count-1:0] inc_en, // Per-register increment
   output logic [reg_board_pkg::reg_count-1:0] dec_en  // Per-register decrement
);
   import reg_board_pkg::*;
   import microcode_pkg::*;

   logic      rd_hit;                              // raddr targets this board
   logic      wr_hit;                              // waddr targets this board
   logic      act_live;
   tgt_t      rd_tgt;
   tgt_t      wr_tgt;
   act_code_t act_code;

   assign rd_hit   = raddr[addr_sel_bit] & ~raddr[addr_other_bit];
   assign wr_hit   = waddr[addr_sel_bit] & ~waddr[addr_other_bit];
   assign rd_tgt   = raddr[2:0];
   assign wr_tgt   = waddr[2:0];
   assign act_live = action[act_live_bit];
   assign act_code = action[2:0];

   // Targets 4 to 7 fall outside the loop and belong to other boards
   always_comb begin
      for (int i = 0; i < reg_count; i++) begin
         rd_sel[i] = rd_hit && (rd_tgt == tgt_t'(i));
         wr_en[i]  = wr_hit && (wr_tgt == tgt_t'(i));
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Step actions
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      inc_en = '0;
      dec_en = '0;                                 // PC never decrements
      if (act_live) begin
         case (act_code)
            act_inc_pc: inc_en[reg_pc] = 1'b1;
            act_inc_dr: inc_en[reg_dr] = 1'b1;
            act_dec_dr: dec_en[reg_dr] = 1'b1;
            act_inc_ac: inc_en[reg_ac] = 1'b1;
            act_dec_ac: dec_en[reg_ac] = 1'b1;
            act_inc_sp: inc_en[reg_sp] = 1'b1;
            act_dec_sp: dec_en[reg_sp] = 1'b1;
            default: ;                             // Code 1 acts elsewhere
         endcase
      end
   end

endmodule

/* logic/microcode_pkg.sv */
// Microcode field definitions
package microcode_pkg;

   localparam int uaddr_w   = 5;                   // raddr and waddr width
   localparam int uaction_w = 4;                   // action width

   typedef logic [uaddr_w-1:0]   uaddr_t;          // Read or write address field
   typedef logic [uaction_w-1:0] uaction_t;        // Action field
   typedef logic [2:0]           tgt_t;            // Target within a board
   typedef logic [2:0]           act_code_t;       // Action code within a board

   //////////////////////////////////////////////////////////////////////////
   // Address decode
   //////////////////////////////////////////////////////////////////////////

   localparam int addr_sel_bit   = 3;              // Must be 1 for this board
   localparam int addr_other_bit = 4;              // Must be 0 for this board

   //////////////////////////////////////////////////////////////////////////
   // Action decode
   //////////////////////////////////////////////////////////////////////////

   localparam int act_live_bit = 3;                // Action enable bit

   localparam act_code_t act_inc_pc = 3'd0;
   localparam act_code_t act_inc_dr = 3'd2;
   localparam act_code_t act_dec_dr = 3'd3;
   localparam act_code_t act_inc_ac = 3'd4;
   localparam act_code_t act_dec_ac = 3'd5;
   localparam act_code_t act_inc_sp = 3'd6;
   localparam act_code_t act_dec_sp = 3'd7;

endpackage

/* logic/reg_board.sv */
// Register board top level
`timescale 1ns/1ns

module reg_board (
   input  logic                                    clk4,     // Board clock
   input  logic                                    rst_n,
   input  microcode_pkg::uaddr_t                   raddr,    // Microcode read field
   input  microcode_pkg::uaddr_t                   waddr,    // Microcode write field
   input  microcode_pkg::uaction_t                 action,   // Microcode action
   input  reg_board_pkg::word_t                    ibus_in,  // Processor bus in
   output reg_board_pkg::word_t                    ibus_out, // Processor bus out
   output logic                                    ibus_oe,  // Bus output enable
   output reg_board_pkg::word_t                    pc,       // Program counter
   output reg_board_pkg::word_t                    ac,       // Accumulator
   output logic                                    fz,       // AC is zero
   output reg_board_pkg::fp_byte_t                 fpd,      // Front panel data
   output logic [reg_board_pkg::fp_slot_count-1:0] fp_sel    // Front panel strobes
);
   import reg_board_pkg::*;

   ////////////////////////////////////////////////////////////////////////////
   // Local signals
   ////////////////////////////////////////////////////////////////////////////

   logic [reg_count-1:0] rd_sel;                   // Read select, one-hot
   logic [reg_count-1:0] wr_en;
   logic [reg_count-1:0] inc_en;
   logic [reg_count-1:0] dec_en;
   word_t                dr;                       // Data register value
   word_t                sp;                       // Stack pointer value

   ////////////////////////////////////////////////////////////////////////////
   // Decode and registers
   ////////////////////////////////////////////////////////////////////////////

   microcode_decoder u_decoder (
      .raddr  (raddr),
      .waddr  (waddr),
      .action (action),
      .rd_sel (rd_sel),
      .wr_en  (wr_en),
      .inc_en (inc_en),
      .dec_en (dec_en)
   );

   major_register u_pc (.clk4(clk4), .rst_n(rst_n), .load_value(ibus_in),
                        .wr(wr_en[reg_pc]), .inc(inc_en[reg_pc]),
                        .dec(dec_en[reg_pc]), .value(pc), .zero());

   major_register u_dr (.clk4(clk4), .rst_n(rst_n), .load_value(ibus_in),
                        .wr(wr_en[reg_dr]), .inc(inc_en[reg_dr]),
                        .dec(dec_en[reg_dr]), .value(dr), .zero());

   major_register u_ac (.clk4(clk4), .rst_n(rst_n), .load_value(ibus_in),
                        .wr(wr_en[reg_ac]), .inc(inc_en[reg_ac]),
                        .dec(dec_en[reg_ac]), .value(ac), .zero(fz));

   major_register u_sp (.clk4(clk4), .rst_n(rst_n), .load_value(ibus_in),
                        .wr(wr_en[reg_sp]), .inc(inc_en[reg_sp]),
                        .dec(dec_en[reg_sp]), .value(sp), .zero());

   ////////////////////////////////////////////////////////////////////////////
   // Bus read port and front panel
   ////////////////////////////////////////////////////////////////////////////

   ibus_read_port u_read_port (
      .clk4     (clk4),
      .rst_n    (rst_n),
      .rd_sel   (rd_sel),
      .pc_value (pc),
      .dr_value (dr),
      .ac_value (ac),
      .sp_value (sp),
      .ibus_out (ibus_out),
      .ibus_oe  (ibus_oe)
   );

   front_panel_scanner u_scanner (
      .clk4     (clk4),
      .rst_n    (rst_n),
      .pc_value (pc),
      .dr_value (dr),
      .ac_value (ac),
      .sp_value (sp),
      .fpd      (fpd),
      .fp_sel   (fp_sel)
   );

endmodule

/* logic/reg_board_pkg.sv */
// Register board datapath definitions
package reg_board_pkg;

   //////////////////////////////////////////////////////////////////////////
   // Word and byte widths
   //////////////////////////////////////////////////////////////////////////

   localparam int word_w    = 16;                 // Processor bus width
   localparam int fp_byte_w = 8;                  // Front panel data width

   typedef logic [word_w-1:0]    word_t;          // One register or bus word
   typedef logic [fp_byte_w-1:0] fp_byte_t;       // One front panel byte
   typedef logic [1:0]           reg_idx_t;       // Major register index

   //////////////////////////////////////////////////////////////////////////
   // Major registers
   //////////////////////////////////////////////////////////////////////////

   localparam reg_idx_t reg_pc = 2'd0;            // Program counter
   localparam reg_idx_t reg_dr = 2'd1;            // Data register
   localparam reg_idx_t reg_ac = 2'd2;            // Accumulator
   localparam reg_idx_t reg_sp = 2'd3;            // Stack pointer
   localparam int       reg_count = 4;

   // Front panel scan order, low byte first
   typedef enum logic [2:0] {
      pc_lo, pc_hi, dr_lo, dr_hi, ac_lo, ac_hi, sp_lo, sp_hi
   } fp_slot_e;

   localparam int fp_slot_count   = 8;             // One select line per slot
   localparam int fp_dwell_cycles = 4;             // Clocks spent on each slot
   localparam int fp_dwell_w      = $clog2(fp_dwell_cycles);

endpackage

/* testbench/reg_board_assert.sv */
// Register board assertions
`timescale 1ns/1ns

module reg_board_assert (
   input logic                                    clk4,
   input logic                                    rst_n,
   input microcode_pkg::uaddr_t                   raddr,
   input logic                                    ibus_oe,
   input reg_board_pkg::word_t                    ac,
   input logic                                    fz,
   input logic [reg_board_pkg::fp_slot_count-1:0] fp_sel
);

   // Never more than one strobe, exactly one once the scanner runs
   a_fp_sel_onehot: assert property (@(posedge clk4)
      $onehot0(fp_sel) && (!(rst_n && $past(rst_n)) || $onehot(fp_sel)))
      else $error("fp_sel is not a single strobe");

   a_fz_zero: assert property (@(posedge clk4) disable iff (!rst_n) fz == (ac == '0))
      else $error("fz disagrees with a zero test of ac");

   // Bus enable follows a board read one cycle earlier
   a_oe_after_read: assert property (@(posedge clk4) disable iff (!rst_n)
      ibus_oe |-> $past(raddr[3] && !raddr[4] && !raddr[2]))
      else $error("ibus_oe high without a board read");

endmodule

bind reg_board reg_board_assert u_assert (
   .clk4    (clk4),
   .rst_n   (rst_n),
   .raddr   (raddr),
   .ibus_oe (ibus_oe),
   .ac      (ac),
   .fz      (fz),
   .fp_sel  (fp_sel)
);

/* testbench/reg_board_tb.sv */
// Register board testbench
`timescale 1ns/1ns

module reg_board_tb;
   import reg_board_pkg::*;
   import microcode_pkg::*;

   typedef struct packed {
      uaddr_t   raddr;
      uaddr_t   waddr;
      uaction_t action;
      word_t    data;                              // Driven on ibus_in
      logic     exp_oe;                            // ibus_oe expected next cycle
   } row_t;

   logic                     clk4;
   logic                     rst_n;
   uaddr_t                   raddr;
   uaddr_t                   waddr;
   uaction_t                 action;
   word_t                    ibus_in;
   word_t                    ibus_out;
   logic                     ibus_oe;
   word_t                    pc;
   word_t                    ac;
   logic                     fz;
   fp_byte_t                 fpd;
   logic [fp_slot_count-1:0] fp_sel;

   word_t  model_reg [0:reg_count-1];              // Reference PC, DR, AC, SP
   word_t  exp_bus;                                // ibus_out for the next cycle
   row_t   rows [$];                               // Stimulus table
   integer seed      = 32'h2c58;
   int     chk_count = 0;
   int     err_count = 0;

   reg_board i_reg_board (.*);

   initial begin
      clk4 = 1'b0;
      forever #5 clk4 = ~clk4;                     // 10 ns period
   end

   ///////////////////////////////////////////////////////////////////////////
   // Compare tasks
   ///////////////////////////////////////////////////////////////////////////

   task automatic check_word(input string name, input word_t exp, input word_t act);
      chk_count++;
      if (act !== exp) begin
         err_count++;
         $display("CHECK FAILED %s expected %h got %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      chk_count++;
      if (act !== exp) begin
         err_count++;
         $display("CHECK FAILED %s expected %h got %h", name, exp, act);
      end
   endtask

   task automatic check_byte(input string name, input fp_byte_t exp, input fp_byte_t act);
      chk_count++;
      if (act !== exp) begin
         err_count++;
         $display("CHECK FAILED %s expected %h got %h", name, exp, act);
      end
   endtask

   ///////////////////////////////////////////////////////////////////////////
   // Reference model and table runner
   ///////////////////////////////////////////////////////////////////////////

   function automatic logic on_board(input uaddr_t a);
      return a[3] && !a[4] && !a[2];               // Board hit, targets 0 to 3
   endfunction

   task automatic apply_model(input row_t r);
      int   w_tgt;
      int   s_tgt;
      logic s_dec;
      w_tgt = -1;
      s_tgt = -1;
      s_dec = 1'b0;
      if (on_board(r.waddr)) w_tgt = int'(r.waddr[1:0]);
      if (r.action[3] && r.action[2:0] != 3'd1) begin
         s_tgt = int'(r.action[2:1]);              // Codes pair up per register
         s_dec = r.action[0];                      // Odd codes count down
      end
      if (w_tgt >= 0) model_reg[w_tgt] = r.data;
      if (s_tgt >= 0 && s_tgt != w_tgt) begin     // Write wins over a step
         if (s_dec) model_reg[s_tgt] = model_reg[s_tgt] - 16'd1;
         else model_reg[s_tgt] = model_reg[s_tgt] + 16'd1;
      end
      exp_bus = on_board(r.raddr) ? model_reg[r.raddr[1:0]] : 16'h0000;
   endtask

   task automatic add_row(input uaddr_t ra, input uaddr_t wa, input uaction_t act,
                          input word_t d, input logic oe);
      row_t r;
      r.raddr  = ra;
      r.waddr  = wa;
      r.action = act;
      r.data   = d;
      r.exp_oe = oe;
      rows.push_back(r);
   endtask

   task automatic step_row(input row_t r);
      raddr   = r.raddr;
      waddr   = r.waddr;
      action  = r.action;
      ibus_in = r.data;
      apply_model(r);
      @(posedge clk4);
      #1;                                          // Outputs settled after the edge
      check_word("pc", model_reg[reg_pc], pc);
      check_word("ac", model_reg[reg_ac], ac);
      check_bit("fz", model_reg[reg_ac] == 16'h0000, fz);
      check_word("ibus_out", exp_bus, ibus_out);
      check_bit("ibus_oe", r.exp_oe, ibus_oe);
   endtask

   task automatic run_rows(input string name);
      int errs;
      errs = err_count;
      foreach (rows[i]) step_row(rows[i]);
      rows.delete();
      raddr   = '0;                                // Idle fields
      waddr   = '0;
      action  = '0;
      ibus_in = '0;
      $display("test %s errors %0d", name, err_count - errs);
   endtask

   task automatic wait_slot(input int slot, input int limit);
      logic [fp_slot_count-1:0] want;
      int                       n;
      want       = '0;
      want[slot] = 1'b1;
      n          = 0;
      while (fp_sel !== want && n < limit) begin
         @(posedge clk4);
         #1;
         n++;
      end
      if (fp_sel !== want) begin
         err_count++;
         $display("timeout waiting for front panel slot %0d", slot);
      end else begin
         check_byte("fpd", model_reg[slot / 2][(slot % 2) * 8 +: 8], fpd);
      end
   endtask

   ///////////////////////////////////////////////////////////////////////////
   // Test sequence
   ///////////////////////////////////////////////////////////////////////////

   initial begin
      int     errs;
      uaddr_t ra;
      rst_n     = 1'b0;
      raddr     = '0;
      waddr     = '0;
      action    = '0;
      ibus_in   = '0;
      model_reg = '{default: 16'h0000};
      repeat (16) @(posedge clk4);
      #1;
      check_word("pc", 16'h0000, pc);
      check_word("ac", 16'h0000, ac);
      check_word("ibus_out", 16'h0000, ibus_out);
      check_bit("ibus_oe", 1'b0, ibus_oe);
      check_bit("fz", 1'b1, fz);
      $display("test reset errors %0d", err_count);
      rst_n = 1'b1;

      add_row(5'h00, 5'h08, 4'h0, 16'h1234, 1'b0); // Write each register
      add_row(5'h00, 5'h09, 4'h0, 16'h5a5a, 1'b0);
      add_row(5'h00, 5'h0a, 4'h0, 16'h00ff, 1'b0);
      add_row(5'h00, 5'h0b, 4'h0, 16'hfffe, 1'b0);
      add_row(5'h08, 5'h00, 4'h0, 16'h0000, 1'b1); // Read them back
      add_row(5'h09, 5'h00, 4'h0, 16'h0000, 1'b1);
      add_row(5'h0a, 5'h00, 4'h0, 16'h0000, 1'b1);
      add_row(5'h0b, 5'h00, 4'h0, 16'h0000, 1'b1);
      run_rows("write_read");

      add_row(5'h00, 5'h0a, 4'h0, 16'hffff, 1'b0);
      add_row(5'h0a, 5'h00, 4'hc, 16'h0000, 1'b1); // AC wraps up to zero
      add_row(5'h0a, 5'h00, 4'hd, 16'h0000, 1'b1); // And back down
      add_row(5'h00, 5'h08, 4'h0, 16'hffff, 1'b0);
      add_row(5'h08, 5'h00, 4'h8, 16'h0000, 1'b1); // PC wraps
      add_row(5'h00, 5'h0b, 4'h0, 16'h0000, 1'b0);
      add_row(5'h0b, 5'h00, 4'hf, 16'h0000, 1'b1); // SP wraps below zero
      add_row(5'h0b, 5'h00, 4'he, 16'h0000, 1'b1);
      add_row(5'h09, 5'h00, 4'hb, 16'h0000, 1'b1); // DR down then up
      add_row(5'h09, 5'h00, 4'ha, 16'h0000, 1'b1);
      add_row(5'h09, 5'h00, 4'h9, 16'h0000, 1'b1); // Code 1, no effect
      add_row(5'h0b, 5'h00, 4'h4, 16'h0000, 1'b1); // Action not live
      add_row(5'h0a, 5'h0a, 4'hc, 16'h0042, 1'b1); // Write beats step
      run_rows("steps");

      add_row(5'h00, 5'h08, 4'h0, 16'h2211, 1'b0); // Distinct bytes for the panel
      add_row(5'h00, 5'h09, 4'h0, 16'h4433, 1'b0);
      add_row(5'h00, 5'h0a, 4'h0, 16'h6655, 1'b0);
      add_row(5'h00, 5'h0b, 4'h0, 16'h8877, 1'b0);
      add_row(5'h18, 5'h18, 4'h0, 16'hdead, 1'b0); // Bit 4 set
      add_row(5'h02, 5'h01, 4'h0, 16'hbeef, 1'b0); // Bit 3 clear
      add_row(5'h0c, 5'h0e, 4'h0, 16'hcafe, 1'b0); // Other boards
      add_row(5'h0f, 5'h0d, 4'h0, 16'hf00d, 1'b0);
      add_row(5'h08, 5'h00, 4'h0, 16'h0000, 1'b1);
      run_rows("off_board");

      errs = err_count;
      for (int k = 0; k <= fp_slot_count; k++) begin
         wait_slot(k % fp_slot_count,
                   (k == 0) ? 2 * fp_slot_count * fp_dwell_cycles : fp_dwell_cycles + 1);
      end
      $display("test scanner errors %0d", err_count - errs);

      for (int i = 0; i < 200; i++) begin
         ra = uaddr_t'($random(seed));
         add_row(ra, uaddr_t'($random(seed)), uaction_t'($random(seed)),
                 word_t'($random(seed)), on_board(ra));
      end
      run_rows("random");

      $display("checks %0d errors %0d", chk_count, err_count);
      if (err_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

/* verilog.f */
logic/reg_board_pkg.sv
logic/microcode_pkg.sv
logic/microcode_decoder.sv
logic/major_register.sv
logic/ibus_read_port.sv
logic/front_panel_scanner.sv
logic/reg_board.sv
testbench/reg_board_assert.sv
testbench/reg_board_tb.sv
